/* common/zx_config.svh */
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// CPU bus
`define ZX_CPU_AW 16
`define ZX_DW 8

// SDRAM byte address and word width
`define ZX_RAM_AW 24
`define ZX_RAM_QW 16

// Divider bits, slowest CPU period is 2**5 cycles
`define ZX_CE_CNT_W 5

// ROM images sit above the 1 MB RAM area
`define ZX_ROM_PREFIX 3'b101

// Fixed RAM banks behind 4000h and 8000h
`define ZX_BANK_4000 6'd5
`define ZX_BANK_8000 6'd2

// Low bits of a 16K bank
`define ZX_BANK_AW 14

`endif

/* common/zx_pkg.sv */
package zx_pkg;

	// Machine memory layout, latched at reset
	typedef enum logic [2:0] {
		std128 = 3'd0,
		p1024  = 3'd1,
		pf1024 = 3'd2,
		zx48   = 3'd3,
		plus3  = 3'd4
	} memory_mode_e;

	// CPU clock selection, unknown codes run at 3.5 MHz
	typedef enum logic [2:0] {
		freq_3m5 = 3'd0,
		freq_7m  = 3'd1,
		freq_14m = 3'd2,
		freq_28m = 3'd3,
		freq_56m = 3'd4
	} cpu_freq_e;

	// 16K ROM page inside the ROM region
	typedef logic [3:0] rom_page_t;

endpackage

/* common/cpu_bus_if.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

interface cpu_bus_if;
	logic [`ZX_CPU_AW-1:0] addr;
	logic [`ZX_DW-1:0] dout; // CPU write data
	logic mreq;
	logic iorq;
	logic rd;
	logic wr;
	logic m1;

	modport paging (
		input addr,
		input dout,
		input iorq,
		input wr,
		input m1
	);

	modport mapping (
		input addr
	);

	modport memory (
		input addr,
		input dout,
		input mreq,
		input rd,
		input wr
	);
endinterface

/* rtl/clock_enables.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module clock_enables
	import zx_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  cpu_freq_e cpu_freq,
	input  logic ram_ready,
	output logic ce_cpu_p,
	output logic ce_cpu_n,
	output logic cpu_en
);
	logic [`ZX_CE_CNT_W-1:0] counter;
	logic [`ZX_CE_CNT_W-1:0] turbo;
	logic [`ZX_CE_CNT_W-1:0] turbo_req;
	logic [`ZX_CE_CNT_W-1:0] half;
	logic [2:0] shift;
	logic [1:0] timeout;
	logic cpu_p;
	logic cpu_n;

	always_comb begin
		case (cpu_freq)
			freq_7m: shift = 3'd1;
			freq_14m: shift = 3'd2;
			freq_28m: shift = 3'd3;
			freq_56m: shift = 3'd4;
			default: shift = 3'd0;
		endcase
	end

	assign turbo_req = {`ZX_CE_CNT_W{1'b1}} >> shift;
	assign half = turbo ^ (turbo >> 1); // Top bit of the active mask

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			cpu_p <= 1'b0;
			cpu_n <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			cpu_p <= (counter & turbo) == '0;
			cpu_n <= (counter & turbo) == half;
		end
	end

	// Mask swaps and stall release happen only on n slots
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			turbo <= '1;
			cpu_en <= 1'b1;
			timeout <= 2'd0;
		end else if (cpu_n) begin
			if (timeout != 2'd0)
				timeout <= timeout + 1'b1;
			if (turbo != turbo_req) begin
				cpu_en <= 1'b0;
				timeout <= 2'd1; // Wraps after three more slots
				turbo <= turbo_req;
			end else if (!cpu_en && timeout == 2'd0 && ram_ready) begin
				cpu_en <= 1'b1;
			end else if (turbo[`ZX_CE_CNT_W-1 -: 2] == 2'b00 && !ram_ready) begin
				cpu_en <= 1'b0; // 14 MHz and up waits for SDRAM
			end
		end
	end

	assign ce_cpu_p = cpu_en & cpu_p;
	assign ce_cpu_n = cpu_en & cpu_n;

	a_ce_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n));

endmodule

/* memory/page_registers.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module page_registers
	import zx_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	cpu_bus_if.paging bus,
	input  memory_mode_e memory_mode,
	output memory_mode_e active_mode,
	output logic [`ZX_DW-1:0] reg_7ffd,
	output logic [`ZX_DW-1:0] reg_1ffd,
	output logic [2:0] page_128k
);
	logic [`ZX_DW-1:0] reg_eff7;
	logic io_wr;
	logic io_wr_old;
	logic io_wr_rise;
	logic is_p1024;
	logic is_plus3;
	logic page_disable;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;
	logic sel_dffd;

	assign io_wr = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_rise = io_wr & ~io_wr_old;

	assign is_p1024 = active_mode == p1024;
	assign is_plus3 = active_mode == plus3;

	// EFF7 bit 2 turns the 7FFD lock back on in p1024
	assign page_disable = (active_mode == zx48)
		| (~is_p1024 & reg_7ffd[5])
		| (is_p1024 & reg_eff7[2] & reg_7ffd[5]);

	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3)
		& ~page_disable;
	assign sel_1ffd = (bus.addr[15:12] == 4'b0001) & ~bus.addr[1] & is_plus3
		& ~page_disable;
	assign sel_eff7 = (bus.addr[15:12] == 4'b1110) & ~bus.addr[3] & is_p1024;
	assign sel_dffd = (bus.addr == 16'hdffd) & (active_mode == pf1024);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_old <= 1'b0;
			active_mode <= memory_mode; // New mode only through reset
			reg_7ffd <= '0;
			reg_1ffd <= '0;
			reg_eff7 <= '0;
			page_128k <= 3'd0;
		end else begin
			io_wr_old <= io_wr;
			if (io_wr_rise) begin
				if (sel_7ffd) begin
					reg_7ffd <= bus.dout;
					if (is_p1024 && !reg_eff7[2])
						page_128k <= {bus.dout[5], bus.dout[7:6]};
				end else if (sel_1ffd) begin
					reg_1ffd <= bus.dout;
				end
				if (sel_dffd)
					page_128k <= bus.dout[2:0];
				if (sel_eff7)
					reg_eff7 <= bus.dout;
			end
		end
	end

endmodule

/* memory/addr_mapper.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module addr_mapper
	import zx_pkg::*;
(
	cpu_bus_if.mapping bus,
	input  memory_mode_e active_mode,
	input  logic [`ZX_DW-1:0] reg_7ffd,
	input  logic [`ZX_DW-1:0] reg_1ffd,
	input  logic [2:0] page_128k,
	output logic [`ZX_RAM_AW-1:0] ram_addr_map,
	output logic write_ok
);
	rom_page_t rom_page;
	logic [5:0] bank;
	logic [2:0] special_bank;
	logic [1:0] slot;
	logic special;
	logic is_zx48;

	assign slot = bus.addr[15:14];
	assign is_zx48 = active_mode == zx48;
	assign special = (active_mode == plus3) & reg_1ffd[0];

	assign rom_page = (active_mode == plus3) ? {2'b10, reg_1ffd[2], reg_7ffd[4]}
		: {is_zx48, 2'b11, is_zx48 | reg_7ffd[4]};

	// +3 all-RAM sets 0123, 4567, 4563, 4763
	always_comb begin
		case (reg_1ffd[2:1])
			2'd0: special_bank = {1'b0, slot};
			2'd1: special_bank = {1'b1, slot};
			2'd2: special_bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
			default: special_bank = (slot == 2'd3) ? 3'd3
				: (slot == 2'd1) ? 3'd7 : {1'b1, slot};
		endcase
	end

	always_comb begin
		if (special)
			bank = {3'd0, special_bank};
		else begin
			case (slot)
				2'd1: bank = `ZX_BANK_4000;
				2'd2: bank = `ZX_BANK_8000;
				default: bank = {page_128k, reg_7ffd[2:0]}; // Slot 0 unused here
			endcase
		end
	end

	always_comb begin
		if (slot == 2'd0 && !special)
			ram_addr_map = {{(`ZX_RAM_AW - 21){1'b0}}, `ZX_ROM_PREFIX, rom_page,
				bus.addr[`ZX_BANK_AW-1:0]};
		else
			ram_addr_map = {{(`ZX_RAM_AW - 20){1'b0}}, bank, bus.addr[`ZX_BANK_AW-1:0]};
	end

	assign write_ok = (slot != 2'd0) | special;

endmodule

/* memory/ram_port.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module ram_port (
	input  logic clk_sys,
	input  logic reset,
	cpu_bus_if.memory bus,
	input  logic [`ZX_RAM_AW-1:0] ram_addr_map,
	input  logic write_ok,
	input  logic ram_ack,
	input  logic [`ZX_RAM_QW-1:0] ram_q,
	output logic ram_req,
	output logic [`ZX_RAM_AW-1:0] ram_addr,
	output logic ram_we,
	output logic [`ZX_DW-1:0] ram_din,
	output logic [1:0] ram_ds,
	output logic ram_ready,
	output logic [`ZX_DW-1:0] cpu_din
);
	logic mem_rd;
	logic mem_wr;
	logic rd_old;
	logic rd_old2;
	logic wr_old;
	logic new_rd;
	logic new_wr;
	logic new_req;

	assign mem_rd = bus.mreq & bus.rd;
	assign mem_wr = bus.mreq & bus.wr & write_ok; // ROM writes never reach SDRAM

	assign new_rd = rd_old & ~rd_old2; // Extra cycle lets the address settle
	assign new_wr = mem_wr & ~wr_old;
	assign new_req = new_rd | new_wr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_old <= 1'b0;
			rd_old2 <= 1'b0;
			wr_old <= 1'b0;
			ram_req <= 1'b0;
			ram_we <= 1'b0;
		end else begin
			rd_old <= mem_rd;
			rd_old2 <= rd_old;
			wr_old <= mem_wr;
			if (new_req) begin
				ram_req <= ~ram_req;
				ram_we <= new_wr;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			ram_addr <= ram_addr_map;
			ram_din <= bus.dout;
			ram_ds <= new_wr ? {ram_addr_map[0], ~ram_addr_map[0]} : 2'b11;
		end
	end

	assign ram_ready = (ram_ack == ram_req) & ~new_req;
	assign cpu_din = ram_addr[0] ? ram_q[15:8] : ram_q[7:0];

	a_one_outstanding: assert property (@(posedge clk_sys) disable iff (reset)
		new_req |-> (ram_ack == ram_req));

endmodule

/* rtl/zx_memory_top.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module zx_memory_top
	import zx_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	input  cpu_freq_e cpu_freq,
	input  memory_mode_e memory_mode,
	input  logic [`ZX_CPU_AW-1:0] cpu_addr,
	input  logic [`ZX_DW-1:0] cpu_dout,
	input  logic cpu_mreq,
	input  logic cpu_iorq,
	input  logic cpu_rd,
	input  logic cpu_wr,
	input  logic cpu_m1,
	input  logic ram_ack,
	input  logic [`ZX_RAM_QW-1:0] ram_q,
	output logic ce_cpu_p,
	output logic ce_cpu_n,
	output logic cpu_en,
	output logic [`ZX_DW-1:0] cpu_din,
	output logic ram_req,
	output logic [`ZX_RAM_AW-1:0] ram_addr,
	output logic ram_we,
	output logic [`ZX_DW-1:0] ram_din,
	output logic [1:0] ram_ds
);
	memory_mode_e active_mode;
	logic [`ZX_DW-1:0] reg_7ffd;
	logic [`ZX_DW-1:0] reg_1ffd;
	logic [2:0] page_128k;
	logic [`ZX_RAM_AW-1:0] ram_addr_map;
	logic write_ok;
	logic ram_ready;

	cpu_bus_if bus ();

	assign bus.addr = cpu_addr;
	assign bus.dout = cpu_dout;
	assign bus.mreq = cpu_mreq;
	assign bus.iorq = cpu_iorq;
	assign bus.rd = cpu_rd;
	assign bus.wr = cpu_wr;
	assign bus.m1 = cpu_m1;

	clock_enables u_clock_enables (
		.clk_sys(clk_sys), .reset(reset), .cpu_freq(cpu_freq), .ram_ready(ram_ready),
		.ce_cpu_p(ce_cpu_p), .ce_cpu_n(ce_cpu_n), .cpu_en(cpu_en)
	);

	page_registers u_page_registers (
		.clk_sys(clk_sys), .reset(reset), .bus(bus.paging), .memory_mode(memory_mode),
		.active_mode(active_mode), .reg_7ffd(reg_7ffd), .reg_1ffd(reg_1ffd),
		.page_128k(page_128k)
	);

	addr_mapper u_addr_mapper (
		.bus(bus.mapping), .active_mode(active_mode), .reg_7ffd(reg_7ffd),
		.reg_1ffd(reg_1ffd), .page_128k(page_128k),
		.ram_addr_map(ram_addr_map), .write_ok(write_ok)
	);

	ram_port u_ram_port (
		.clk_sys(clk_sys), .reset(reset), .bus(bus.memory),
		.ram_addr_map(ram_addr_map), .write_ok(write_ok),
		.ram_ack(ram_ack), .ram_q(ram_q), .ram_req(ram_req), .ram_addr(ram_addr),
		.ram_we(ram_we), .ram_din(ram_din), .ram_ds(ram_ds),
		.ram_ready(ram_ready), .cpu_din(cpu_din)
	);

endmodule

/* tb/sdram_model.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module sdram_model (
	input  logic clk_sys,
	input  logic reset,
	input  logic ram_req,
	input  logic [`ZX_RAM_AW-1:0] ram_addr,
	input  logic ram_we,
	input  logic [`ZX_DW-1:0] ram_din,
	input  logic [1:0] ram_ds,
	output logic ram_ack,
	output logic [`ZX_RAM_QW-1:0] ram_q
);
	logic [`ZX_RAM_QW-1:0] mem [int]; // Keyed by word address
	logic [31:0] lfsr = 32'h9a8c9a69;
	logic [2:0] lat;
	logic [2:0] wait_cnt;
	logic [`ZX_RAM_QW-1:0] word;
	logic busy;
	int key;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Unwritten words read back a pattern of the whole word address
	function automatic logic [15:0] fill_word(input logic [22:0] w);
		return w[15:0] ^ {w[22:16], w[22:14]};
	endfunction

	always @(posedge clk_sys) begin
		if (reset) begin
			ram_ack <= 1'b0;
			ram_q <= '0;
			busy <= 1'b0;
			wait_cnt <= '0;
		end else if (!busy && ram_req != ram_ack) begin
			for (int i = 0; i < 3; i++) begin
				lat = {lat[1:0], lfsr[0]};
				lfsr = lfsr_next(lfsr);
			end
			wait_cnt <= lat; // 1 to 8 cycles to the ack
			busy <= 1'b1;
		end else if (busy) begin
			if (wait_cnt == 0) begin
				key = ram_addr[`ZX_RAM_AW-1:1];
				word = mem.exists(key) ? mem[key] : fill_word(ram_addr[`ZX_RAM_AW-1:1]);
				if (ram_we) begin
					if (ram_ds[1])
						word[15:8] = ram_din;
					if (ram_ds[0])
						word[7:0] = ram_din;
					mem[key] = word;
				end
				ram_q <= word;
				ram_ack <= ram_req;
				busy <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

endmodule

/* tb/tb_zx_memory.sv */
`timescale 1ns/100ps
`include "zx_config.svh"

module tb_zx_memory
	import zx_pkg::*;
();
	typedef struct {
		bit rst;
		memory_mode_e mode;
		int nio;
		logic [15:0] io_a [3];
		logic [7:0] io_d [3];
		logic [15:0] addr;
		bit is_wr;
		bit exp_req;
		logic [23:0] exp_addr;
		logic [1:0] exp_ds;
	} row_t;

	logic clk_sys = 1'b0;
	logic reset;
	cpu_freq_e cpu_freq;
	memory_mode_e memory_mode;
	logic [15:0] cpu_addr;
	logic [7:0] cpu_dout;
	logic cpu_mreq, cpu_iorq, cpu_rd, cpu_wr, cpu_m1;
	logic ram_ack;
	logic [15:0] ram_q;
	logic ce_cpu_p, ce_cpu_n, cpu_en;
	logic [7:0] cpu_din;
	logic ram_req, ram_we;
	logic [23:0] ram_addr;
	logic [7:0] ram_din;
	logic [1:0] ram_ds;
	row_t rows[$];
	logic [31:0] lfsr_state = 32'h9a8c9a69;
	int errors = 0;
	int cycle = 0;

	zx_memory_top dut (.*);

	sdram_model u_sdram (
		.clk_sys(clk_sys), .reset(reset), .ram_req(ram_req), .ram_addr(ram_addr),
		.ram_we(ram_we), .ram_din(ram_din), .ram_ds(ram_ds), .ram_ack(ram_ack), .ram_q(ram_q)
	);

	always #5 clk_sys = ~clk_sys;
	always @(posedge clk_sys) cycle <= cycle + 1;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic add_row(input bit rst, input memory_mode_e mode, input int nio,
		input logic [15:0] a0, input logic [7:0] d0, input logic [15:0] a1,
		input logic [7:0] d1, input logic [15:0] a2, input logic [7:0] d2,
		input logic [15:0] addr, input bit is_wr, input bit exp_req,
		input logic [23:0] exp_addr, input logic [1:0] exp_ds);
		row_t r;
		r.rst = rst;
		r.mode = mode;
		r.nio = nio;
		r.io_a = '{a0, a1, a2};
		r.io_d = '{d0, d1, d2};
		r.addr = addr;
		r.is_wr = is_wr;
		r.exp_req = exp_req;
		r.exp_addr = exp_addr;
		r.exp_ds = exp_ds;
		rows.push_back(r);
	endtask

	task automatic apply_reset(input memory_mode_e mode);
		memory_mode = mode;
		reset = 1'b1;
		next_cycle();
		next_cycle();
		reset = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_dout = data;
		cpu_iorq = 1'b1;
		cpu_wr = 1'b1;
		next_cycle();
		next_cycle();
		cpu_iorq = 1'b0;
		cpu_wr = 1'b0;
		next_cycle();
	endtask

	task automatic mem_access(input logic [15:0] addr, input bit is_wr,
		input logic [7:0] data, output bit got_req, output logic [23:0] req_addr,
		output logic [1:0] req_ds, output logic [7:0] rdata);
		logic req_before;
		int n;
		req_before = ram_req;
		got_req = 1'b0;
		req_addr = '0;
		req_ds = '0;
		rdata = '0;
		cpu_addr = addr;
		cpu_dout = data;
		cpu_mreq = 1'b1;
		if (is_wr)
			cpu_wr = 1'b1;
		else
			cpu_rd = 1'b1;
		for (n = 0; n < 8 && !got_req; n++) begin
			next_cycle();
			if (ram_req != req_before)
				got_req = 1'b1;
		end
		if (got_req) begin
			req_addr = ram_addr;
			req_ds = ram_ds;
			n = 0;
			while (ram_ack != ram_req && n < 20) begin
				next_cycle();
				n++;
			end
			if (ram_ack != ram_req) begin
				$display("SDRAM acknowledge never arrived for address %h", addr);
				errors++;
			end else begin
				rdata = cpu_din; // Valid while ready
			end
		end
		cpu_mreq = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		next_cycle();
	endtask

	task automatic wait_pulse(input bit use_n, output int t);
		int n;
		n = 0;
		next_cycle();
		while (!(use_n ? ce_cpu_n : ce_cpu_p) && n < 80) begin
			next_cycle();
			n++;
		end
		if (!(use_n ? ce_cpu_n : ce_cpu_p)) begin
			$display("No clock enable pulse seen within the timeout");
			errors++;
		end
		t = cycle;
	endtask

	task automatic check_cadence(input int f);
		int period, t0, tn, t1, n;
		cpu_freq = cpu_freq_e'(f);
		period = (1 << `ZX_CE_CNT_W) >> f;
		n = 0;
		while (cpu_en && n < 70) begin // No stall when the speed is unchanged
			next_cycle();
			n++;
		end
		n = 0;
		while (!cpu_en && n < 400) begin
			next_cycle();
			n++;
		end
		if (!cpu_en) begin
			$display("CPU stall after a speed change did not end");
			errors++;
		end
		wait_pulse(1'b0, t0);
		wait_pulse(1'b1, tn);
		wait_pulse(1'b0, t1);
		if (t1 - t0 != period) begin
			$display("[FAIL] ce_cpu_p period got %h expected %h", t1 - t0, period);
			errors++;
		end
		if (tn - t0 != period / 2) begin
			$display("[FAIL] ce_cpu_n offset got %h expected %h", tn - t0, period / 2);
			errors++;
		end
	endtask

	task automatic build_table();
		for (int b = 0; b < 8; b++) // 128K banks at C000
			add_row(1, std128, 1, 16'h7ffd, b, 0, 0, 0, 0, 16'hc000, 0, 1, b << 14, 2'b11);
		add_row(1, std128, 1, 16'h7ffd, 8'h00, 0, 0, 0, 0, 16'h0000, 0, 1, 24'h158000, 2'b11);
		add_row(1, std128, 1, 16'h7ffd, 8'h10, 0, 0, 0, 0, 16'h0000, 0, 1, 24'h15c000, 2'b11);
		// Lock bit ignores the second write
		add_row(1, std128, 2, 16'h7ffd, 8'h21, 16'h7ffd, 8'h06, 0, 0, 16'hc000, 0, 1,
			24'h004000, 2'b11);
		add_row(1, std128, 1, 16'h7ffd, 8'h06, 0, 0, 0, 0, 16'hc000, 0, 1, 24'h018000, 2'b11);
		add_row(1, std128, 0, 0, 0, 0, 0, 0, 0, 16'h1234, 1, 0, 0, 2'b00);
		add_row(0, std128, 0, 0, 0, 0, 0, 0, 0, 16'h4000, 1, 1, 24'h014000, 2'b01);
		add_row(0, std128, 0, 0, 0, 0, 0, 0, 0, 16'h4001, 1, 1, 24'h014001, 2'b10);
		add_row(1, plus3, 1, 16'h1ffd, 8'h01, 0, 0, 0, 0, 16'h0010, 1, 1, 24'h000010, 2'b01);
		add_row(1, plus3, 1, 16'h1ffd, 8'h07, 0, 0, 0, 0, 16'h4000, 0, 1, 24'h01c000, 2'b11);
		add_row(1, plus3, 1, 16'h1ffd, 8'h05, 0, 0, 0, 0, 16'hc000, 0, 1, 24'h00c000, 2'b11);
		add_row(1, plus3, 1, 16'h1ffd, 8'h03, 0, 0, 0, 0, 16'h8000, 0, 1, 24'h018000, 2'b11);
		add_row(1, plus3, 2, 16'h1ffd, 8'h04, 16'h7ffd, 8'h10, 0, 0, 16'h0000, 0, 1,
			24'h16c000, 2'b11);
		add_row(1, p1024, 1, 16'h7ffd, 8'he3, 0, 0, 0, 0, 16'hc000, 0, 1, 24'h0ec000, 2'b11);
		add_row(1, p1024, 2, 16'heff7, 8'h04, 16'h7ffd, 8'hc2, 0, 0, 16'hc000, 0, 1,
			24'h008000, 2'b11);
		add_row(1, pf1024, 2, 16'hdffd, 8'h05, 16'h7ffd, 8'h03, 0, 0, 16'hc000, 0, 1,
			24'h0ac000, 2'b11);
		// Mode input alone changes nothing until reset
		add_row(1, std128, 1, 16'h7ffd, 8'h10, 0, 0, 0, 0, 16'h0000, 0, 1, 24'h15c000, 2'b11);
		add_row(0, zx48, 0, 0, 0, 0, 0, 0, 0, 16'h0000, 0, 1, 24'h15c000, 2'b11);
		add_row(1, zx48, 0, 0, 0, 0, 0, 0, 0, 16'h0000, 0, 1, 24'h17c000, 2'b11);
	endtask

	initial begin
		row_t r;
		bit got;
		logic [23:0] got_addr;
		logic [1:0] got_ds;
		logic [7:0] got_data;
		logic [15:0] bank, off, data;
		logic [23:0] exp_addr;
		reset = 1'b1;
		cpu_freq = freq_3m5;
		memory_mode = std128;
		cpu_addr = '0;
		cpu_dout = '0;
		cpu_mreq = 1'b0;
		cpu_iorq = 1'b0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_m1 = 1'b0;
		apply_reset(std128);

		for (int f = 0; f < 5; f++)
			check_cadence(f);
		cpu_freq = freq_3m5;

		build_table();
		foreach (rows[i]) begin
			r = rows[i];
			if (r.rst)
				apply_reset(r.mode);
			else
				memory_mode = r.mode;
			for (int j = 0; j < r.nio; j++)
				io_write(r.io_a[j], r.io_d[j]);
			mem_access(r.addr, r.is_wr, 8'h5a, got, got_addr, got_ds, got_data);
			if (got != r.exp_req) begin
				$display("Row %0d request presence wrong, got %0d expected %0d",
					i, got, r.exp_req);
				errors++;
			end else if (got) begin
				if (got_addr != r.exp_addr) begin
					$display("[FAIL] row %0d ram_addr got %h expected %h",
						i, got_addr, r.exp_addr);
					errors++;
				end
				if (got_ds != r.exp_ds) begin
					$display("[FAIL] row %0d ram_ds got %h expected %h", i, got_ds, r.exp_ds);
					errors++;
				end
				if (ram_we != r.is_wr) begin
					$display("[FAIL] row %0d ram_we got %h expected %h", i, ram_we, r.is_wr);
					errors++;
				end
				if (r.is_wr && ram_din != 8'h5a) begin
					$display("[FAIL] row %0d ram_din got %h expected %h", i, ram_din, 8'h5a);
					errors++;
				end
			end
		end

		apply_reset(std128);
		for (int k = 0; k < 16; k++) begin
			random_bits(3, bank);
			random_bits(14, off);
			random_bits(8, data);
			exp_addr = (bank << 14) | off;
			io_write(16'h7ffd, bank[7:0]);
			mem_access(16'hc000 | off, 1, data[7:0], got, got_addr, got_ds, got_data);
			if (!got || got_addr != exp_addr) begin
				$display("[FAIL] ram_addr got %h expected %h", got_addr, exp_addr);
				errors++;
			end
			mem_access(16'hc000 | off, 0, 8'h00, got, got_addr, got_ds, got_data);
			if (!got || got_data != data[7:0]) begin
				$display("[FAIL] cpu_din got %h expected %h", got_data, data[7:0]);
				errors++;
			end
		end

		$display("Checks done, errors: %0d", errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* src.f */
+incdir+common
common/zx_pkg.sv
common/cpu_bus_if.sv
rtl/clock_enables.sv
memory/page_registers.sv
memory/addr_mapper.sv
memory/ram_port.sv
rtl/zx_memory_top.sv
tb/sdram_model.sv
tb/tb_zx_memory.sv
